// ==== l2_pkg.sv ====
`default_nettype none

package l2_pkg;

   ////////////////////////////////////////
   // physical address geometry
   ////////////////////////////////////////

   localparam int l2_addr_w   = 40;
   localparam int l2_tag_w    = 22;
   localparam int l2_idx_w    = 10;
   // byte offset within a 64 byte line
   localparam int l2_line_lsb = 6;
   // two sub-line bits sit between offset and set index
   localparam int l2_sub_w    = 2;
   localparam int l2_idx_lsb  = l2_line_lsb + l2_sub_w;
   localparam int l2_tag_lsb  = l2_idx_lsb + l2_idx_w;
   // dram addresses are in 32 byte units
   localparam int l2_dram_lsb = 5;
   localparam int l2_sets     = 1 << l2_idx_w;

   // field view of a physical address, msb first
   typedef struct packed {
      logic [l2_tag_w-1:0]    tag;
      logic [l2_idx_w-1:0]    idx;
      logic [l2_sub_w-1:0]    sub;
      logic [l2_line_lsb-1:0] off;
   } l2_addr_fields_t;

   // same 40 bits seen as a flat vector or as named fields
   typedef union packed {
      logic [l2_addr_w-1:0] raw;
      l2_addr_fields_t      f;
   } l2_addr_u;

endpackage

`default_nettype wire

// ==== l2_miss_addr_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_miss_addr_buf #(
   parameter int MB_ENTRIES = 8
) (
   input  logic                            rclk,
   input  logic                            reset,
   // write port from the c2 lookup stage
   input  logic                            mb_wr_en,
   input  logic [$clog2(MB_ENTRIES)-1:0]   mb_wr_id,
   input  logic [l2_pkg::l2_addr_w-1:0]    mb_wr_addr,
   // read port picked by entry id
   input  logic [$clog2(MB_ENTRIES)-1:0]   mb_rd_id,
   output logic [l2_pkg::l2_addr_w-1:0]    mb_read_data
);
   import l2_pkg::*;

   ////////////////////////////////////////
   // miss address storage
   ////////////////////////////////////////

   logic [l2_addr_w-1:0] mb_mem [MB_ENTRIES];

   // one write per cycle
   always_ff @(posedge rclk) begin
      if (mb_wr_en) begin
         mb_mem[mb_wr_id] <= mb_wr_addr;
      end
   end

   // flow through read that the arbiter flops downstream
   assign mb_read_data = mb_mem[mb_rd_id];

   ////////////////////////////////////////
   // id range checks
   ////////////////////////////////////////

   // ids come from the miss buffer control and must name a real entry
   a_wr_id_range: assert property (@(posedge rclk) disable iff (reset)
      mb_wr_en |-> (int'(mb_wr_id) < MB_ENTRIES))
      else $error("miss buffer write id %0d out of range", mb_wr_id);

   // read id is sampled whenever it is driven to a known value
   a_rd_id_range: assert property (@(posedge rclk) disable iff (reset)
      !$isunknown(mb_rd_id) |-> (int'(mb_rd_id) < MB_ENTRIES))
      else $error("miss buffer read id %0d out of range", mb_rd_id);

endmodule

`default_nettype wire

// ==== l2_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_tag_array (
   input  logic                           rclk,
   input  logic                           reset,
   // set index from the c3 pipeline stage
   input  logic [l2_pkg::l2_idx_w-1:0]    vuad_idx_c3,
   // tag fill port
   input  logic                           tag_wr_en,
   input  logic [l2_pkg::l2_idx_w-1:0]    tag_wr_idx,
   input  logic [l2_pkg::l2_tag_w-1:0]    tag_wr_tag,
   output logic [l2_pkg::l2_tag_w-1:0]    tagdp_evict_tag_c4
);
   import l2_pkg::*;

   ////////////////////////////////////////
   // one way tag store
   ////////////////////////////////////////

   // contents are unknown until a set is filled
   logic [l2_tag_w-1:0] tag_mem [l2_sets];

   always_ff @(posedge rclk) begin
      if (tag_wr_en) begin
         tag_mem[tag_wr_idx] <= tag_wr_tag;
      end
   end

   ////////////////////////////////////////
   // c3 read registered into c4
   ////////////////////////////////////////

   // nonblocking read returns the old tag on a same set write
   always_ff @(posedge rclk) begin
      if (reset) begin
         tagdp_evict_tag_c4 <= '0;
      end else begin
         tagdp_evict_tag_c4 <= tag_mem[vuad_idx_c3];
      end
   end

endmodule

`default_nettype wire

// ==== l2_wb_addr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_wb_addr_queue #(
   parameter int WB_DEPTH = 4
) (
   input  logic                                            rclk,
   input  logic                                            reset,
   // push side, evicted line from c4
   input  logic                                            arbctl_evict_c4,
   input  logic [l2_pkg::l2_addr_w-1:0]                    wb_write_addr,
   // pop side, drain toward dram
   input  logic                                            wb_pop,
   input  logic                                            rdma_wr_req,
   output logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_line_lsb]  wb_read_data,
   output logic                                            wbctl_wr_addr_sel,
   output logic                                            wb_or_rdma_wr_req_en,
   output logic                                            wb_empty
);
   import l2_pkg::*;

   localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
   localparam int CNT_W = $clog2(WB_DEPTH + 1);

   logic [l2_addr_w-1:l2_line_lsb] wb_mem [WB_DEPTH];
   logic [PTR_W-1:0]               wr_ptr;
   logic [PTR_W-1:0]               rd_ptr;
   logic [CNT_W-1:0]               count;
   logic                           wb_full;

   // wrap for depths that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      ptr_next = (p == PTR_W'(WB_DEPTH - 1)) ? '0 : p + PTR_W'(1);
   endfunction

   ////////////////////////////////////////
   // circular fifo
   ////////////////////////////////////////

   // only the line address is kept
   always_ff @(posedge rclk) begin
      if (arbctl_evict_c4) begin
         wb_mem[wr_ptr] <= wb_write_addr[l2_addr_w-1:l2_line_lsb];
      end
   end

   always_ff @(posedge rclk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (arbctl_evict_c4)
            wr_ptr <= ptr_next(wr_ptr);
         if (wb_pop)
            rd_ptr <= ptr_next(rd_ptr);
         // count only moves when push and pop differ
         case ({arbctl_evict_c4, wb_pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
         endcase
      end
   end

   assign wb_read_data = wb_mem[rd_ptr];
   assign wb_empty     = (count == '0);
   assign wb_full      = (count == CNT_W'(WB_DEPTH));

   ////////////////////////////////////////
   // dram write source select
   ////////////////////////////////////////

   // queue head has priority over rdma
   assign wbctl_wr_addr_sel    = wb_pop;
   assign wb_or_rdma_wr_req_en = wb_pop | rdma_wr_req;

   a_no_push_full: assert property (@(posedge rclk) disable iff (reset)
      arbctl_evict_c4 |-> !wb_full)
      else $error("writeback queue push while full");

   a_no_pop_empty: assert property (@(posedge rclk) disable iff (reset)
      wb_pop |-> !wb_empty)
      else $error("writeback queue pop while empty");

endmodule

`default_nettype wire

// ==== l2_evict_addr_dp.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_evict_addr_dp (
   input  logic                                            rclk,
   input  logic                                            reset,
   // lookup address from the arbiter
   input  logic [l2_pkg::l2_addr_w-1:0]                    arbdp_cam_addr_px2,
   input  logic                                            sehold,
   // miss buffer and fill buffer read ports
   input  logic [l2_pkg::l2_addr_w-1:0]                    mb_read_data,
   input  logic [l2_pkg::l2_addr_w-1:0]                    fb_read_data,
   input  logic                                            mbctl_arb_l2rd_en,
   input  logic                                            fbctl_arb_l2rd_en,
   input  logic                                            mbctl_arb_dramrd_en,
   input  logic                                            mux1_mbsel_px1,
   // write address sources
   input  logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_line_lsb]  wb_read_data,
   input  logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_line_lsb]  rdma_read_data,
   input  logic                                            wbctl_wr_addr_sel,
   input  logic                                            wb_or_rdma_wr_req_en,
   // evicted tag and evict strobe at c4
   input  logic [l2_pkg::l2_tag_w-1:0]                     tagdp_evict_tag_c4,
   input  logic                                            arbctl_evict_c4,
   output logic [l2_pkg::l2_addr_w-1:0]                    evicttag_addr_px2,
   output logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_idx_lsb]   lkup_addr_c1,
   output logic [l2_pkg::l2_addr_w-1:0]                    mb_write_addr,
   output logic [l2_pkg::l2_idx_w-1:0]                     vuad_idx_c3,
   output logic [l2_pkg::l2_addr_w-1:0]                    wb_write_addr,
   output logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_line_lsb]  evict_addr,
   output logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_dram_lsb]  sctag_dram_addr
);
   import l2_pkg::*;

   logic [l2_addr_w-1:0]           mbf_addr_px2;
   logic [l2_addr_w-1:0]           fbf_addr_px2;
   logic                           mux1_mbsel_px2;
   logic [l2_addr_w-1:l2_dram_lsb] dram_read_addr;
   logic [l2_addr_w-1:l2_line_lsb] dram_wr_addr;
   logic [l2_addr_w-1:l2_line_lsb] evict_rd_data;
   logic                           dram_pick_d2;
   l2_addr_u                       inst_addr_c1;
   l2_addr_u                       inst_addr_c2;
   l2_addr_u                       inst_addr_c3;
   l2_addr_u                       inst_addr_c4;
   l2_addr_u                       evict_addr_c4;

   ////////////////////////////////////////
   // px2 arbitration mux between mb and fb
   ////////////////////////////////////////

   // each copy only loads on its own read strobe
   always_ff @(posedge rclk) begin
      if (reset) begin
         mbf_addr_px2   <= '0;
         fbf_addr_px2   <= '0;
         mux1_mbsel_px2 <= 1'b0;
      end else begin
         if (mbctl_arb_l2rd_en)
            mbf_addr_px2 <= mb_read_data;
         if (fbctl_arb_l2rd_en)
            fbf_addr_px2 <= fb_read_data;
         // single select flop for the whole 40 bit mux
         mux1_mbsel_px2 <= mux1_mbsel_px1;
      end
   end

   assign evicttag_addr_px2 = mux1_mbsel_px2 ? mbf_addr_px2 : fbf_addr_px2;

   ////////////////////////////////////////
   // dram read and write address flops
   ////////////////////////////////////////

   // rdma unless the wb queue is being drained
   assign evict_rd_data = wbctl_wr_addr_sel ? wb_read_data : rdma_read_data;

   always_ff @(posedge rclk) begin
      if (reset) begin
         dram_read_addr <= '0;
         dram_wr_addr   <= '0;
         dram_pick_d2   <= 1'b0;
      end else begin
         if (mbctl_arb_dramrd_en)
            dram_read_addr <= mb_read_data[l2_addr_w-1:l2_dram_lsb];
         if (wb_or_rdma_wr_req_en)
            dram_wr_addr <= evict_rd_data;
         // read wins for exactly one cycle after its strobe
         dram_pick_d2 <= mbctl_arb_dramrd_en;
      end
   end

   assign evict_addr      = dram_wr_addr;
   // write addresses are line aligned so bit 5 goes out as zero
   assign sctag_dram_addr = dram_pick_d2 ? dram_read_addr : {dram_wr_addr, 1'b0};

   ////////////////////////////////////////
   // lookup address pipeline c1 to c4
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (reset) begin
         inst_addr_c1 <= '0;
         inst_addr_c2 <= '0;
         inst_addr_c3 <= '0;
         inst_addr_c4 <= '0;
      end else begin
         // sehold freezes c1 only while later stages keep moving
         if (!sehold)
            inst_addr_c1.raw <= arbdp_cam_addr_px2;
         inst_addr_c2 <= inst_addr_c1;
         inst_addr_c3 <= inst_addr_c2;
         inst_addr_c4 <= inst_addr_c3;
      end
   end

   // lookup buffer only compares tag and index
   assign lkup_addr_c1  = inst_addr_c1.raw[l2_addr_w-1:l2_idx_lsb];
   assign mb_write_addr = inst_addr_c2.raw;
   assign vuad_idx_c3   = inst_addr_c3.f.idx;

   // victim line address is old tag over the current set
   always_comb begin
      evict_addr_c4.f.tag = tagdp_evict_tag_c4;
      evict_addr_c4.f.idx = inst_addr_c4.f.idx;
      evict_addr_c4.f.sub = inst_addr_c4.f.sub;
      evict_addr_c4.f.off = '0;
   end

   assign wb_write_addr = arbctl_evict_c4 ? evict_addr_c4.raw : inst_addr_c4.raw;

   // the queue must never select wb data without also enabling the flop
   a_wr_sel_has_en: assert property (@(posedge rclk) disable iff (reset)
      wbctl_wr_addr_sel |-> wb_or_rdma_wr_req_en)
      else $error("wb address selected without write enable");

endmodule

`default_nettype wire

// ==== l2_tag_addr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_tag_addr_top #(
   parameter int MB_ENTRIES = 8,
   parameter int WB_DEPTH   = 4
) (
   input  logic                                            rclk,
   input  logic                                            reset,
   // lookup pipeline
   input  logic [l2_pkg::l2_addr_w-1:0]                    arbdp_cam_addr_px2,
   input  logic                                            sehold,
   input  logic                                            arbctl_evict_c4,
   // miss buffer
   input  logic                                            mb_wr_en,
   input  logic [$clog2(MB_ENTRIES)-1:0]                   mb_wr_id,
   input  logic [l2_pkg::l2_addr_w-1:0]                    mb_wr_addr,
   input  logic [$clog2(MB_ENTRIES)-1:0]                   mb_rd_id,
   input  logic                                            mbctl_arb_l2rd_en,
   input  logic                                            mbctl_arb_dramrd_en,
   // fill buffer and px2 select
   input  logic [l2_pkg::l2_addr_w-1:0]                    fb_read_data,
   input  logic                                            fbctl_arb_l2rd_en,
   input  logic                                            mux1_mbsel_px1,
   // tag fill
   input  logic                                            tag_wr_en,
   input  logic [l2_pkg::l2_idx_w-1:0]                     tag_wr_idx,
   input  logic [l2_pkg::l2_tag_w-1:0]                     tag_wr_tag,
   // writeback drain and rdma
   input  logic                                            wb_pop,
   input  logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_line_lsb]  rdma_read_data,
   input  logic                                            rdma_wr_req,
   output logic [l2_pkg::l2_addr_w-1:0]                    evicttag_addr_px2,
   output logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_idx_lsb]   lkup_addr_c1,
   output logic [l2_pkg::l2_addr_w-1:0]                    mb_write_addr,
   output logic [l2_pkg::l2_idx_w-1:0]                     vuad_idx_c3,
   output logic [l2_pkg::l2_addr_w-1:0]                    wb_write_addr,
   output logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_line_lsb]  evict_addr,
   output logic [l2_pkg::l2_addr_w-1:l2_pkg::l2_dram_lsb]  sctag_dram_addr,
   output logic                                            wb_empty
);
   import l2_pkg::*;

   logic [l2_addr_w-1:0]           mb_read_data;
   logic [l2_tag_w-1:0]            tagdp_evict_tag_c4;
   logic [l2_addr_w-1:l2_line_lsb] wb_read_data;
   logic                           wbctl_wr_addr_sel;
   logic                           wb_or_rdma_wr_req_en;

   // miss address store feeding px2 and dram read
   l2_miss_addr_buf #(.MB_ENTRIES(MB_ENTRIES)) u_mb (
      .rclk(rclk), .reset(reset), .mb_wr_en(mb_wr_en), .mb_wr_id(mb_wr_id),
      .mb_wr_addr(mb_wr_addr), .mb_rd_id(mb_rd_id), .mb_read_data(mb_read_data));

   // victim tag looked up with the c3 index
   l2_tag_array u_tag (
      .rclk(rclk), .reset(reset), .vuad_idx_c3(vuad_idx_c3), .tag_wr_en(tag_wr_en),
      .tag_wr_idx(tag_wr_idx), .tag_wr_tag(tag_wr_tag),
      .tagdp_evict_tag_c4(tagdp_evict_tag_c4));

   l2_wb_addr_queue #(.WB_DEPTH(WB_DEPTH)) u_wbq (
      .rclk(rclk), .reset(reset), .arbctl_evict_c4(arbctl_evict_c4),
      .wb_write_addr(wb_write_addr), .wb_pop(wb_pop), .rdma_wr_req(rdma_wr_req),
      .wb_read_data(wb_read_data), .wbctl_wr_addr_sel(wbctl_wr_addr_sel),
      .wb_or_rdma_wr_req_en(wb_or_rdma_wr_req_en), .wb_empty(wb_empty));

   l2_evict_addr_dp u_dp (
      .rclk(rclk), .reset(reset), .arbdp_cam_addr_px2(arbdp_cam_addr_px2),
      .sehold(sehold), .mb_read_data(mb_read_data), .fb_read_data(fb_read_data),
      .mbctl_arb_l2rd_en(mbctl_arb_l2rd_en), .fbctl_arb_l2rd_en(fbctl_arb_l2rd_en),
      .mbctl_arb_dramrd_en(mbctl_arb_dramrd_en), .mux1_mbsel_px1(mux1_mbsel_px1),
      .wb_read_data(wb_read_data), .rdma_read_data(rdma_read_data),
      .wbctl_wr_addr_sel(wbctl_wr_addr_sel),
      .wb_or_rdma_wr_req_en(wb_or_rdma_wr_req_en),
      .tagdp_evict_tag_c4(tagdp_evict_tag_c4), .arbctl_evict_c4(arbctl_evict_c4),
      .evicttag_addr_px2(evicttag_addr_px2), .lkup_addr_c1(lkup_addr_c1),
      .mb_write_addr(mb_write_addr), .vuad_idx_c3(vuad_idx_c3),
      .wb_write_addr(wb_write_addr), .evict_addr(evict_addr),
      .sctag_dram_addr(sctag_dram_addr));

endmodule

`default_nettype wire

// ==== l2_tag_addr_tests.svh ====
`ifndef L2_TAG_ADDR_TESTS_SVH
`define L2_TAG_ADDR_TESTS_SVH

// 40 bit address from two draws
function automatic logic [l2_addr_w-1:0] rand_addr();
   logic [63:0] wide;
   wide = {$random(seed), $random(seed)};
   return wide[l2_addr_w-1:0];
endfunction

task automatic report_test(input string name);
   tests_done++;
   $display("test %s done, failed checks so far %0d", name, errors);
endtask

// new random px2 address every cycle
task automatic stream_lookups(input int n);
   repeat (n) begin
      @(negedge rclk);
      arbdp_cam_addr_px2 = rand_addr();
   end
endtask

// c1 frozen for n cycles while c2..c4 drain
task automatic hold_c1(input int n);
   stream_lookups(2);
   sehold = 1'b1;
   stream_lookups(n);
   sehold = 1'b0;
   stream_lookups(4);
endtask

task automatic evict_line(input logic [l2_addr_w-1:0] addr, input logic [l2_tag_w-1:0] tag);
   l2_addr_u a;
   a.raw = addr;
   @(negedge rclk);
   tag_wr_en = 1'b1;
   tag_wr_idx = a.f.idx;
   tag_wr_tag = tag;
   @(negedge rclk);
   tag_wr_en = 1'b0;
   arbdp_cam_addr_px2 = a.raw;
   // px2 to c4 is four stages
   repeat (4) @(negedge rclk);
   arbctl_evict_c4 = 1'b1;
   @(negedge rclk);
   arbctl_evict_c4 = 1'b0;
endtask

// pop until the queue reports empty
task automatic drain_queue();
   while (!wb_empty) begin
      wb_pop = 1'b1;
      @(negedge rclk);
      wb_pop = 1'b0;
   end
endtask

task automatic evict_and_drain(input int n);
   logic [l2_addr_w-1:0] t;
   repeat (n) begin
      t = rand_addr();
      evict_line(rand_addr(), t[l2_tag_w-1:0]);
   end
   drain_queue();
endtask

task automatic fill_miss_buf();
   for (int i = 0; i < mb_entries; i++) begin
      @(negedge rclk);
      mb_wr_en = 1'b1;
      mb_wr_id = id_w'(i);
      mb_wr_addr = rand_addr();
   end
   @(negedge rclk);
   mb_wr_en = 1'b0;
endtask

task automatic read_dram(input int id);
   @(negedge rclk);
   mb_rd_id = id_w'(id);
   mbctl_arb_dramrd_en = 1'b1;
   @(negedge rclk);
   mbctl_arb_dramrd_en = 1'b0;
endtask

// both requests together, then rdma alone
task automatic pick_dram_write();
   logic [l2_addr_w-1:0] r;
   r = rand_addr();
   evict_line(rand_addr(), r[l2_tag_w-1:0]);
   r = rand_addr();
   rdma_read_data = r[l2_addr_w-1:l2_line_lsb];
   wb_pop = 1'b1;
   rdma_wr_req = 1'b1;
   @(negedge rclk);
   wb_pop = 1'b0;
   rdma_wr_req = 1'b0;
   @(negedge rclk);
   r = rand_addr();
   rdma_read_data = r[l2_addr_w-1:l2_line_lsb];
   rdma_wr_req = 1'b1;
   @(negedge rclk);
   rdma_wr_req = 1'b0;
   @(negedge rclk);
endtask

task automatic switch_px2_source(input int n);
   logic [l2_addr_w-1:0] r;
   r = rand_addr();
   @(negedge rclk);
   mb_rd_id = r[id_w-1:0];
   mbctl_arb_l2rd_en = 1'b1;
   fb_read_data = rand_addr();
   fbctl_arb_l2rd_en = 1'b1;
   @(negedge rclk);
   mbctl_arb_l2rd_en = 1'b0;
   fbctl_arb_l2rd_en = 1'b0;
   // random select, one bit per cycle
   repeat (n) begin
      r = rand_addr();
      mux1_mbsel_px1 = r[0];
      @(negedge rclk);
   end
   mux1_mbsel_px1 = 1'b0;
endtask

`endif

// ==== l2_tag_addr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_tag_addr_tb;
   import l2_pkg::*;

   localparam int mb_entries = 8;
   localparam int wb_depth = 4;
   localparam int id_w = $clog2(mb_entries);
   // all six tests take about 150 cycles, the rest is margin
   localparam int cycle_limit = 2000;
   localparam logic [31:0] seed_init = 32'hbeec9e7d;

   logic                           rclk = 1'b0;
   logic                           reset;
   logic [l2_addr_w-1:0]           arbdp_cam_addr_px2;
   logic                           sehold;
   logic                           arbctl_evict_c4;
   logic                           mb_wr_en;
   logic [id_w-1:0]                mb_wr_id;
   logic [l2_addr_w-1:0]           mb_wr_addr;
   logic [id_w-1:0]                mb_rd_id;
   logic                           mbctl_arb_l2rd_en;
   logic                           mbctl_arb_dramrd_en;
   logic [l2_addr_w-1:0]           fb_read_data;
   logic                           fbctl_arb_l2rd_en;
   logic                           mux1_mbsel_px1;
   logic                           tag_wr_en;
   logic [l2_idx_w-1:0]            tag_wr_idx;
   logic [l2_tag_w-1:0]            tag_wr_tag;
   logic                           wb_pop;
   logic [l2_addr_w-1:l2_line_lsb] rdma_read_data;
   logic                           rdma_wr_req;
   logic [l2_addr_w-1:0]           evicttag_addr_px2;
   logic [l2_addr_w-1:l2_idx_lsb]  lkup_addr_c1;
   logic [l2_addr_w-1:0]           mb_write_addr;
   logic [l2_idx_w-1:0]            vuad_idx_c3;
   logic [l2_addr_w-1:0]           wb_write_addr;
   logic [l2_addr_w-1:l2_line_lsb] evict_addr;
   logic [l2_addr_w-1:l2_dram_lsb] sctag_dram_addr;
   logic                           wb_empty;

   // reference model state, fed only from the driven inputs
   l2_addr_u                       ref_c1;
   l2_addr_u                       ref_c2;
   l2_addr_u                       ref_c3;
   l2_addr_u                       ref_c4;
   logic [l2_tag_w-1:0]            ref_tag_c4;
   logic [l2_tag_w-1:0]            tag_model [l2_sets];
   logic [l2_addr_w-1:0]           mb_model [mb_entries];
   logic [l2_addr_w-1:l2_line_lsb] wbq_model [$];
   int                             ref_wb_cnt;
   logic [l2_addr_w-1:l2_line_lsb] ref_wr_addr;
   logic [l2_addr_w-1:l2_dram_lsb] ref_rd_addr;
   logic                           ref_pick;
   logic [l2_addr_w-1:0]           ref_mbf;
   logic [l2_addr_w-1:0]           ref_fbf;
   logic                           ref_sel;
   // expected tap values
   l2_addr_u                       exp_wb;
   logic [l2_addr_w-1:l2_idx_lsb]  exp_c1;
   logic [l2_idx_w-1:0]            exp_c3;
   logic [l2_addr_w-1:l2_dram_lsb] exp_dram;
   logic [l2_addr_w-1:0]           exp_px2;
   logic                           exp_empty;

   integer                         seed;
   int                             errors = 0;
   int                             tests_done;
   int                             cycle_count = 0;

   always #4 rclk = ~rclk;

   l2_tag_addr_top #(.MB_ENTRIES(mb_entries), .WB_DEPTH(wb_depth)) dut0 (
      .rclk(rclk), .reset(reset), .arbdp_cam_addr_px2(arbdp_cam_addr_px2),
      .sehold(sehold), .arbctl_evict_c4(arbctl_evict_c4), .mb_wr_en(mb_wr_en),
      .mb_wr_id(mb_wr_id), .mb_wr_addr(mb_wr_addr), .mb_rd_id(mb_rd_id),
      .mbctl_arb_l2rd_en(mbctl_arb_l2rd_en), .mbctl_arb_dramrd_en(mbctl_arb_dramrd_en),
      .fb_read_data(fb_read_data), .fbctl_arb_l2rd_en(fbctl_arb_l2rd_en),
      .mux1_mbsel_px1(mux1_mbsel_px1), .tag_wr_en(tag_wr_en), .tag_wr_idx(tag_wr_idx),
      .tag_wr_tag(tag_wr_tag), .wb_pop(wb_pop), .rdma_read_data(rdma_read_data),
      .rdma_wr_req(rdma_wr_req), .evicttag_addr_px2(evicttag_addr_px2),
      .lkup_addr_c1(lkup_addr_c1), .mb_write_addr(mb_write_addr),
      .vuad_idx_c3(vuad_idx_c3), .wb_write_addr(wb_write_addr), .evict_addr(evict_addr),
      .sctag_dram_addr(sctag_dram_addr), .wb_empty(wb_empty));

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   always @(posedge rclk) begin : model_update
      logic [l2_addr_w-1:l2_line_lsb] head;
      if (reset) begin
         ref_c1 <= '0;
         ref_c2 <= '0;
         ref_c3 <= '0;
         ref_c4 <= '0;
         ref_tag_c4 <= '0;
         ref_wr_addr <= '0;
         ref_rd_addr <= '0;
         ref_pick <= 1'b0;
         ref_mbf <= '0;
         ref_fbf <= '0;
         ref_sel <= 1'b0;
         ref_wb_cnt <= 0;
         wbq_model.delete();
      end else begin
         // c1 freezes under sehold, the rest shift
         if (!sehold)
            ref_c1.raw <= arbdp_cam_addr_px2;
         ref_c2 <= ref_c1;
         ref_c3 <= ref_c2;
         ref_c4 <= ref_c3;
         // old tag wins over a same cycle write
         ref_tag_c4 <= tag_model[ref_c3.f.idx];
         if (tag_wr_en)
            tag_model[tag_wr_idx] <= tag_wr_tag;
         if (mb_wr_en)
            mb_model[mb_wr_id] <= mb_wr_addr;
         if (mbctl_arb_l2rd_en)
            ref_mbf <= mb_model[mb_rd_id];
         if (fbctl_arb_l2rd_en)
            ref_fbf <= fb_read_data;
         ref_sel <= mux1_mbsel_px1;
         if (mbctl_arb_dramrd_en)
            ref_rd_addr <= mb_model[mb_rd_id][l2_addr_w-1:l2_dram_lsb];
         ref_pick <= mbctl_arb_dramrd_en;
         // take the head before this cycle's victim goes in
         head = (wbq_model.size() > 0) ? wbq_model[0] : '0;
         if (wb_pop && wbq_model.size() > 0)
            void'(wbq_model.pop_front());
         if (arbctl_evict_c4)
            wbq_model.push_back(exp_wb.raw[l2_addr_w-1:l2_line_lsb]);
         ref_wb_cnt <= wbq_model.size();
         // queue head beats rdma
         if (wb_pop)
            ref_wr_addr <= head;
         else if (rdma_wr_req)
            ref_wr_addr <= rdma_read_data;
      end
   end

   // victim is old tag, c4 bits 17:6, zero offset
   always_comb begin
      exp_wb = ref_c4;
      if (arbctl_evict_c4) begin
         exp_wb.f.tag = ref_tag_c4;
         exp_wb.f.off = '0;
      end
   end

   assign exp_c1    = ref_c1.raw[l2_addr_w-1:l2_idx_lsb];
   assign exp_c3    = ref_c3.f.idx;
   assign exp_dram  = ref_pick ? ref_rd_addr : {ref_wr_addr, 1'b0};
   assign exp_px2   = ref_sel ? ref_mbf : ref_fbf;
   assign exp_empty = (ref_wb_cnt == 0);

   function automatic void flag_mismatch(input string name, input logic [63:0] got,
                                         input logic [63:0] want);
      $display("[FAIL] %s got %0h expected %0h", name, got, want);
      errors++;
   endfunction

   ////////////////////////////////////////
   // output checks
   ////////////////////////////////////////

   c1_tap: assert property (@(posedge rclk) disable iff (reset) lkup_addr_c1 == exp_c1)
      else flag_mismatch("lkup_addr_c1", 64'($sampled(lkup_addr_c1)), 64'($sampled(exp_c1)));
   c2_tap: assert property (@(posedge rclk) disable iff (reset) mb_write_addr == ref_c2.raw)
      else flag_mismatch("mb_write_addr", 64'($sampled(mb_write_addr)),
                         64'($sampled(ref_c2.raw)));
   c3_tap: assert property (@(posedge rclk) disable iff (reset) vuad_idx_c3 == exp_c3)
      else flag_mismatch("vuad_idx_c3", 64'($sampled(vuad_idx_c3)), 64'($sampled(exp_c3)));
   c4_tap: assert property (@(posedge rclk) disable iff (reset) wb_write_addr == exp_wb.raw)
      else flag_mismatch("wb_write_addr", 64'($sampled(wb_write_addr)),
                         64'($sampled(exp_wb.raw)));
   wr_hold: assert property (@(posedge rclk) disable iff (reset) evict_addr == ref_wr_addr)
      else flag_mismatch("evict_addr", 64'($sampled(evict_addr)), 64'($sampled(ref_wr_addr)));
   dram_sel: assert property (@(posedge rclk) disable iff (reset) sctag_dram_addr == exp_dram)
      else flag_mismatch("sctag_dram_addr", 64'($sampled(sctag_dram_addr)),
                         64'($sampled(exp_dram)));
   px2_mux: assert property (@(posedge rclk) disable iff (reset) evicttag_addr_px2 == exp_px2)
      else flag_mismatch("evicttag_addr_px2", 64'($sampled(evicttag_addr_px2)),
                         64'($sampled(exp_px2)));
   wbq_level: assert property (@(posedge rclk) disable iff (reset) wb_empty == exp_empty)
      else flag_mismatch("wb_empty", 64'($sampled(wb_empty)), 64'($sampled(exp_empty)));

   `include "l2_tag_addr_tests.svh"

   // hard stop if a wait never finishes
   always @(posedge rclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout, run still busy after %0d cycles", cycle_count);
         $display("Errors found");
         $finish;
      end
   end

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      seed = seed_init;
      tests_done = 0;
      reset = 1'b1;
      arbdp_cam_addr_px2 = '0;
      sehold = 1'b0;
      arbctl_evict_c4 = 1'b0;
      mb_wr_en = 1'b0;
      mb_wr_id = '0;
      mb_wr_addr = '0;
      mb_rd_id = '0;
      mbctl_arb_l2rd_en = 1'b0;
      mbctl_arb_dramrd_en = 1'b0;
      fb_read_data = '0;
      fbctl_arb_l2rd_en = 1'b0;
      mux1_mbsel_px1 = 1'b0;
      tag_wr_en = 1'b0;
      tag_wr_idx = '0;
      tag_wr_tag = '0;
      wb_pop = 1'b0;
      rdma_read_data = '0;
      rdma_wr_req = 1'b0;
      repeat (4) @(posedge rclk);
      @(negedge rclk);
      reset = 1'b0;

      stream_lookups(32);
      report_test("lookup pipeline");
      hold_c1(6);
      report_test("c1 hold");
      evict_and_drain(3);
      report_test("eviction");
      fill_miss_buf();
      read_dram(3);
      read_dram(0);
      read_dram(7);
      report_test("dram read");
      pick_dram_write();
      report_test("dram write select");
      switch_px2_source(16);
      report_test("px2 arbitration");

      // let the last strobes clear the checks
      repeat (2) @(negedge rclk);
      $display("tests run %0d, failed checks %0d", tests_done, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== l2_tag_addr_top.f ====
+incdir+.
l2_pkg.sv
l2_miss_addr_buf.sv
l2_tag_array.sv
l2_wb_addr_queue.sv
l2_evict_addr_dp.sv
l2_tag_addr_top.sv
l2_tag_addr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= l2_tag_addr_tb
FILELIST  ?= l2_tag_addr_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
